// ==== sources.f ====
design/key_extract_pkg.sv
design/tenant_table.sv
design/cfg_stream_parser.sv
design/phv_unpack.sv
design/key_select.sv
design/key_assemble.sv
design/key_extract.sv
dv/tb_key_extract.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f sources.f \
        --top-module tb_key_extract -o tb_key_extract \
    && ./obj_dir/tb_key_extract | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== dv/tb_key_extract.sv ====
`timescale 1ns/1ps

module tb_key_extract
    import key_extract_pkg::*;
();

    localparam int STG         = 2;
    localparam int KEX         = 1;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;

    logic      clk;
    logic      rst_n;
    phv_t      phv_in;
    logic      phv_valid_in;
    cfg_data_t cfg_in_data;
    logic      cfg_in_valid;
    logic      cfg_in_last;
    phv_t      phv_out;
    logic      phv_valid_out;
    key_t      key_out;
    logic      key_valid_out;
    key_t      key_mask_out;
    cfg_data_t cfg_out_data;
    logic      cfg_out_valid;
    logic      cfg_out_last;

    // reference copies of both tables
    key_off_t  mdl_off [16];
    key_t      mdl_mask [16];
    key_t      wr_vals [16];

    // expected results, entry 2 is due at the current falling edge
    logic      want_valid [3];
    key_t      want_key [3];
    key_t      want_mask [3];
    phv_t      want_phv [3];
    cfg_data_t want_cfg_data;
    logic      want_cfg_valid;
    logic      want_cfg_last;

    logic [31:0] lcg_state = 32'hb21d6f5a;
    int          errors = 0;
    int          checks = 0;

    key_extract #(.STAGE_ID(STG), .KEY_EX_ID(KEX)) u_key_extract (
        .clk(clk), .rst_n(rst_n), .phv_in(phv_in), .phv_valid_in(phv_valid_in),
        .cfg_in_data(cfg_in_data), .cfg_in_valid(cfg_in_valid), .cfg_in_last(cfg_in_last),
        .phv_out(phv_out), .phv_valid_out(phv_valid_out), .key_out(key_out),
        .key_valid_out(key_valid_out), .key_mask_out(key_mask_out),
        .cfg_out_data(cfg_out_data), .cfg_out_valid(cfg_out_valid),
        .cfg_out_last(cfg_out_last)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [1151:0] rand_bits();
        logic [1151:0] w;
        for (int i = 0; i < 36; i++) begin
            w[i*32 +: 32] = next_rand();
        end
        return w;
    endfunction

    // byte 0 of the beat becomes the top byte
    function automatic cfg_data_t byte_swap(input cfg_data_t d);
        cfg_data_t s;
        for (int i = 0; i < 64; i++) begin
            s[511-8*i -: 8] = d[8*i +: 8];
        end
        return s;
    endfunction

    function automatic cont6_t cont6(input phv_t p, input int i);
        return p[CONT6_LSB + i*CONT6_W +: CONT6_W];
    endfunction

    function automatic cont4_t cont4(input phv_t p, input int i);
        return p[CONT4_LSB + i*CONT4_W +: CONT4_W];
    endfunction

    function automatic cont2_t cont2(input phv_t p, input int i);
        return p[CONT2_LSB + i*CONT2_W +: CONT2_W];
    endfunction

    // type 2 is 6B, 1 is 4B, 0 is 2B, 3 gives zero
    function automatic operand_t operand(input phv_t p, input logic imm_flag,
                                         input operand_t imm, input logic [1:0] ctype,
                                         input cont_idx_t idx);
        cont6_t   c6;
        cont4_t   c4;
        cont2_t   c2;
        operand_t lo;
        c6 = cont6(p, int'(idx));
        c4 = cont4(p, int'(idx));
        c2 = cont2(p, int'(idx));
        case (ctype)
            2'd2:    lo = c6[7:0];
            2'd1:    lo = c4[7:0];
            2'd0:    lo = c2[7:0];
            default: lo = 8'd0;
        endcase
        return imm_flag ? imm : lo;
    endfunction

    function automatic key_t model_key(input phv_t p);
        key_off_t   off;
        com_op_t    op;
        operand_t   a;
        operand_t   b;
        logic       cond;
        logic [4:0] cbits;
        // tenant is vlan id bits 7:4, vlan id at phv 140:129
        off = mdl_off[p[136:133]];
        // stage 0 operation is the highest, at 355:336
        op = p[355 - 20*STG -: 20];
        a = operand(p, op[17], op[16:9], op[13:12], op[11:9]);
        b = operand(p, op[8], op[7:0], op[4:3], op[2:0]);
        case (op[19:18])
            2'd0:    cond = a > b;
            2'd1:    cond = a >= b;
            2'd2:    cond = a == b;
            default: cond = 1'b1;
        endcase
        cbits = 5'd0;
        cbits[4-STG] = cond;
        return {cont6(p, int'(off[17:15])), cont6(p, int'(off[14:12])),
                cont4(p, int'(off[11:9])), cont4(p, int'(off[8:6])),
                cont2(p, int'(off[5:3])), cont2(p, int'(off[2:0])), cbits};
    endfunction

    task automatic check_value(input string name, input logic [PHV_W-1:0] got,
                               input logic [PHV_W-1:0] want);
        checks++;
        assert (got === want) else begin
            $display("MISMATCH time %0t %s got %0h expected %0h", $time, name, got, want);
            errors++;
        end
    endtask

    // checks the results due at this falling edge, then drives the next inputs
    task automatic step(input logic pv, input phv_t p, input cfg_data_t cd,
                        input logic cv, input logic cl, input logic fwd);
        @(negedge clk);
        check_value("key_valid_out", PHV_W'(key_valid_out), PHV_W'(want_valid[2]));
        check_value("phv_valid_out", PHV_W'(phv_valid_out), PHV_W'(want_valid[2]));
        check_value("key_out", PHV_W'(key_out), PHV_W'(want_key[2]));
        check_value("key_mask_out", PHV_W'(key_mask_out), PHV_W'(want_mask[2]));
        check_value("phv_out", phv_out, want_phv[2]);
        check_value("cfg_out_valid", PHV_W'(cfg_out_valid), PHV_W'(want_cfg_valid));
        check_value("cfg_out_last", PHV_W'(cfg_out_last), PHV_W'(want_cfg_last));
        check_value("cfg_out_data", PHV_W'(cfg_out_data), PHV_W'(want_cfg_data));
        assert ((key_out[4:0] & 5'b11011) == 5'd0) else begin
            $display("key_out has a condition bit of another stage set at time %0t", $time);
            errors++;
        end
        for (int i = 2; i > 0; i--) begin
            want_valid[i] = want_valid[i-1];
            want_key[i]   = want_key[i-1];
            want_mask[i]  = want_mask[i-1];
            want_phv[i]   = want_phv[i-1];
        end
        phv_in         = p;
        phv_valid_in   = pv;
        cfg_in_data    = cd;
        cfg_in_valid   = cv;
        cfg_in_last    = cl;
        want_valid[0]  = pv;
        want_key[0]    = pv ? model_key(p) : '0;
        want_mask[0]   = pv ? mdl_mask[p[136:133]] : '0;
        want_phv[0]    = p;
        // a forwarded beat shows up unchanged, a swallowed one as zeros
        want_cfg_data  = fwd ? cd : '0;
        want_cfg_valid = fwd & cv;
        want_cfg_last  = fwd & cl;
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, '0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic send_phv(input phv_t p);
        step(1'b1, p, '0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic send_all_tenants();
        phv_t p;
        for (int t = 0; t < 16; t++) begin
            p = PHV_W'(rand_bits());
            p[136:133] = 4'(t);
            send_phv(p);
        end
        idle(4);
    endtask

    // claimed packet, one data beat per entry of wr_vals
    task automatic write_table(input logic is_mask, input tenant_t start, input int count);
        cfg_data_t hdr;
        cfg_data_t raw;
        tenant_t   idx;
        hdr = '0;
        hdr[368 +: 8]  = {5'(STG), 3'(KEX)};
        hdr[380 +: 4]  = is_mask ? 4'h1 : 4'h0;
        hdr[320 +: 16] = 16'hf2f1;
        hdr[384 +: 4]  = start;
        step(1'b0, '0, hdr, 1'b1, 1'b0, 1'b0);
        idx = start;
        for (int i = 0; i < count; i++) begin
            raw = CFG_W'(rand_bits());
            if (is_mask) begin
                raw[511 -: 197] = wr_vals[i];
            end else begin
                raw[511 -: 18] = wr_vals[i][17:0];
            end
            step(1'b0, '0, byte_swap(raw), 1'b1, i == count - 1, 1'b0);
            if (is_mask) begin
                mdl_mask[idx] = wr_vals[i];
            end else begin
                mdl_off[idx] = wr_vals[i][17:0];
            end
            idx = idx + 4'd1;
        end
        idle(1);
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_value("key_valid_out", PHV_W'(key_valid_out), '0);
        check_value("phv_valid_out", PHV_W'(phv_valid_out), '0);
        check_value("cfg_out_valid", PHV_W'(cfg_out_valid), '0);
        check_value("cfg_out_last", PHV_W'(cfg_out_last), '0);
        check_value("key_out", PHV_W'(key_out), '0);
    endtask

    // offsets start at index 9 so the write index wraps past 15
    task automatic load_tables();
        for (int i = 0; i < 16; i++) begin
            wr_vals[i] = key_t'(next_rand());
        end
        write_table(1'b0, 4'd9, 16);
        for (int i = 0; i < 16; i++) begin
            wr_vals[i] = KEY_W'(rand_bits());
        end
        write_table(1'b1, 4'd0, 16);
        send_all_tenants();
    endtask

    // every opcode and operand type, immediate below, equal to and above the byte
    task automatic run_comparator_cases();
        phv_t      p;
        cont_idx_t idx;
        operand_t  v;
        operand_t  imm;
        int        typ;
        for (int n = 0; n < 96; n++) begin
            typ = (n / 6) % 4;
            p   = PHV_W'(rand_bits());
            idx = cont_idx_t'(next_rand());
            v   = operand_t'(next_rand() % 32'd254 + 32'd1);
            imm = v + operand_t'((n / 2) % 3) - 8'd1;
            if (typ == 2) begin
                p[CONT6_LSB + int'(idx)*CONT6_W +: 8] = v;
            end else if (typ == 1) begin
                p[CONT4_LSB + int'(idx)*CONT4_W +: 8] = v;
            end else if (typ == 0) begin
                p[CONT2_LSB + int'(idx)*CONT2_W +: 8] = v;
            end
            if (n % 2 == 0) begin
                p[355 - 20*STG -: 20] = {2'(n / 24), 1'b1, imm, 1'b0, 3'd0, 2'(typ), idx};
            end else begin
                p[355 - 20*STG -: 20] = {2'(n / 24), 1'b0, 3'd0, 2'(typ), idx, 1'b1, imm};
            end
            send_phv(p);
        end
        idle(4);
    endtask

    task automatic check_masks_and_bubbles();
        phv_t p;
        wr_vals[0] = KEY_W'(rand_bits());
        write_table(1'b1, 4'd5, 1);
        wr_vals[0] = KEY_W'(rand_bits());
        write_table(1'b1, 4'd12, 1);
        for (int i = 0; i < 12; i++) begin
            p = PHV_W'(rand_bits());
            p[136:133] = (i % 2 == 0) ? 4'd5 : 4'd12;
            // every third cycle is a bubble
            step(i % 3 != 2, p, '0, 1'b0, 1'b0, 1'b1);
        end
        idle(4);
    endtask

    task automatic forward_packet(input logic [7:0] mod_id, input logic [15:0] flag);
        cfg_data_t hdr;
        hdr = CFG_W'(rand_bits());
        hdr[368 +: 8]  = mod_id;
        hdr[320 +: 16] = flag;
        step(1'b0, '0, hdr, 1'b1, 1'b0, 1'b1);
        step(1'b0, '0, CFG_W'(rand_bits()), 1'b1, 1'b0, 1'b1);
        step(1'b0, '0, CFG_W'(rand_bits()), 1'b1, 1'b1, 1'b1);
        idle(1);
    endtask

    task automatic check_forwarding();
        forward_packet({5'(STG + 1), 3'(KEX)}, 16'hf2f1);
        forward_packet({5'(STG), 3'(KEX + 3)}, 16'hf2f1);
        forward_packet({5'(STG), 3'(KEX)}, 16'hf2f0);
        // an offset write leaves the masks alone and a mask write the offsets
        wr_vals[0] = key_t'(next_rand());
        write_table(1'b0, 4'd5, 1);
        wr_vals[0] = KEY_W'(rand_bits());
        write_table(1'b1, 4'd12, 1);
        send_all_tenants();
    endtask

    task automatic stream_random_phvs();
        for (int i = 0; i < 24; i++) begin
            send_phv(PHV_W'(rand_bits()));
        end
        idle(4);
    endtask

    initial begin
        #((8 + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        phv_in         = '0;
        phv_valid_in   = 1'b0;
        cfg_in_data    = '0;
        cfg_in_valid   = 1'b0;
        cfg_in_last    = 1'b0;
        want_cfg_data  = '0;
        want_cfg_valid = 1'b0;
        want_cfg_last  = 1'b0;
        for (int i = 0; i < 3; i++) begin
            want_valid[i] = 1'b0;
            want_key[i]   = '0;
            want_mask[i]  = '0;
            want_phv[i]   = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        load_tables();
        run_comparator_cases();
        check_masks_and_bubbles();
        check_forwarding();
        stream_random_phvs();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== design/key_extract.sv ====
`timescale 1ns/1ps

module key_extract
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID  = 0,
    parameter int KEY_EX_ID = 1
) (
    input  logic      clk,
    input  logic      rst_n,
    input  phv_t      phv_in,
    input  logic      phv_valid_in,
    input  cfg_data_t cfg_in_data,
    input  logic      cfg_in_valid,
    input  logic      cfg_in_last,
    output phv_t      phv_out,
    output logic      phv_valid_out,
    output key_t      key_out,
    output logic      key_valid_out,
    output key_t      key_mask_out,
    output cfg_data_t cfg_out_data,
    output logic      cfg_out_valid,
    output logic      cfg_out_last
);

    tenant_t  wr_index;
    logic     off_wr_en;
    logic     mask_wr_en;
    key_off_t off_wr_data;
    key_t     mask_wr_data;

    tenant_t  tenant;
    tenant_t  tenant_s1;
    cont6_t   cont6_s1 [CONT_COUNT];
    cont4_t   cont4_s1 [CONT_COUNT];
    cont2_t   cont2_s1 [CONT_COUNT];
    com_op_t  com_op_s1;
    phv_t     phv_s1;
    logic     valid_s1;
    key_off_t key_off;

    cont6_t   fields6_s2 [2];
    cont4_t   fields4_s2 [2];
    cont2_t   fields2_s2 [2];
    logic     cond_s2;
    phv_t     phv_s2;
    logic     valid_s2;
    key_t     mask;

    cfg_stream_parser #(.STAGE_ID(STAGE_ID), .KEY_EX_ID(KEY_EX_ID)) u_cfg_parser (
        .clk(clk), .rst_n(rst_n),
        .cfg_in_data(cfg_in_data), .cfg_in_valid(cfg_in_valid), .cfg_in_last(cfg_in_last),
        .cfg_out_data(cfg_out_data), .cfg_out_valid(cfg_out_valid),
        .cfg_out_last(cfg_out_last),
        .wr_index(wr_index), .off_wr_en(off_wr_en), .mask_wr_en(mask_wr_en),
        .off_wr_data(off_wr_data), .mask_wr_data(mask_wr_data)
    );

    // offset read lines up with stage 1, mask read with stage 2
    tenant_table #(.WIDTH(KEY_OFF_W)) u_off_table (
        .clk(clk), .wr_en(off_wr_en), .wr_index(wr_index), .wr_data(off_wr_data),
        .rd_index(tenant), .rd_data(key_off)
    );

    tenant_table #(.WIDTH(KEY_W)) u_mask_table (
        .clk(clk), .wr_en(mask_wr_en), .wr_index(wr_index), .wr_data(mask_wr_data),
        .rd_index(tenant_s1), .rd_data(mask)
    );

    phv_unpack #(.STAGE_ID(STAGE_ID)) u_unpack (
        .clk(clk), .rst_n(rst_n), .phv_in(phv_in), .phv_valid_in(phv_valid_in),
        .tenant(tenant), .tenant_s1(tenant_s1),
        .cont6_s1(cont6_s1), .cont4_s1(cont4_s1), .cont2_s1(cont2_s1),
        .com_op_s1(com_op_s1), .phv_s1(phv_s1), .valid_s1(valid_s1)
    );

    key_select u_select (
        .clk(clk), .rst_n(rst_n),
        .cont6_s1(cont6_s1), .cont4_s1(cont4_s1), .cont2_s1(cont2_s1),
        .com_op_s1(com_op_s1), .key_off(key_off), .phv_s1(phv_s1), .valid_s1(valid_s1),
        .fields6_s2(fields6_s2), .fields4_s2(fields4_s2), .fields2_s2(fields2_s2),
        .cond_s2(cond_s2), .phv_s2(phv_s2), .valid_s2(valid_s2)
    );

    key_assemble #(.STAGE_ID(STAGE_ID)) u_assemble (
        .clk(clk), .rst_n(rst_n),
        .fields6_s2(fields6_s2), .fields4_s2(fields4_s2), .fields2_s2(fields2_s2),
        .cond_s2(cond_s2), .mask(mask), .phv_s2(phv_s2), .valid_s2(valid_s2),
        .key_out(key_out), .key_valid_out(key_valid_out), .key_mask_out(key_mask_out),
        .phv_out(phv_out), .phv_valid_out(phv_valid_out)
    );

endmodule

// ==== design/key_assemble.sv ====
`timescale 1ns/1ps

module key_assemble
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  cont6_t fields6_s2 [2],
    input  cont4_t fields4_s2 [2],
    input  cont2_t fields2_s2 [2],
    input  logic   cond_s2,
    input  key_t   mask,
    input  phv_t   phv_s2,
    input  logic   valid_s2,
    output key_t   key_out,
    output logic   key_valid_out,
    output key_t   key_mask_out,
    output phv_t   phv_out,
    output logic   phv_valid_out
);

    logic [NUM_STAGES-1:0] cond_bits;
    key_t                  key_next;

    // only this stage's condition bit can be set, stage 0 is bit 4
    always_comb begin
        cond_bits = '0;
        cond_bits[NUM_STAGES-1-STAGE_ID] = cond_s2;
    end

    assign key_next = {fields6_s2[0], fields6_s2[1], fields4_s2[0], fields4_s2[1],
                       fields2_s2[0], fields2_s2[1], cond_bits};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_out       <= '0;
            key_mask_out  <= '0;
            key_valid_out <= 1'b0;
            phv_valid_out <= 1'b0;
        end else begin
            key_out       <= valid_s2 ? key_next : '0;
            key_mask_out  <= valid_s2 ? mask : '0;
            key_valid_out <= valid_s2;
            phv_valid_out <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        phv_out <= phv_s2;
    end

    a_key_with_phv: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out == phv_valid_out);

endmodule

// ==== design/key_select.sv ====
`timescale 1ns/1ps

module key_select
    import key_extract_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cont6_t   cont6_s1 [CONT_COUNT],
    input  cont4_t   cont4_s1 [CONT_COUNT],
    input  cont2_t   cont2_s1 [CONT_COUNT],
    input  com_op_t  com_op_s1,
    input  key_off_t key_off,
    input  phv_t     phv_s1,
    input  logic     valid_s1,
    output cont6_t   fields6_s2 [2],
    output cont4_t   fields4_s2 [2],
    output cont2_t   fields2_s2 [2],
    output logic     cond_s2,
    output phv_t     phv_s2,
    output logic     valid_s2
);

    operand_t opa;
    operand_t opb;
    logic     cond;

    function automatic operand_t sel_operand(
        input logic     imm_flag,
        input operand_t imm,
        input logic [1:0] ctype,
        input operand_t lo6,
        input operand_t lo4,
        input operand_t lo2
    );
        if (imm_flag) begin
            return imm;
        end
        case (ctype)
            CT_6B:   return lo6;
            CT_4B:   return lo4;
            CT_2B:   return lo2;
            default: return '0;
        endcase
    endfunction

    // operand a: flag 17, imm 16:9, type 13:12, index 11:9
    assign opa = sel_operand(com_op_s1[17], com_op_s1[16:9], com_op_s1[13:12],
                             cont6_s1[com_op_s1[11:9]][7:0],
                             cont4_s1[com_op_s1[11:9]][7:0],
                             cont2_s1[com_op_s1[11:9]][7:0]);

    // operand b: flag 8, imm 7:0, type 4:3, index 2:0
    assign opb = sel_operand(com_op_s1[8], com_op_s1[7:0], com_op_s1[4:3],
                             cont6_s1[com_op_s1[2:0]][7:0],
                             cont4_s1[com_op_s1[2:0]][7:0],
                             cont2_s1[com_op_s1[2:0]][7:0]);

    always_comb begin
        case (com_op_s1[19:18])
            OP_GT:   cond = (opa > opb);
            OP_GE:   cond = (opa >= opb);
            OP_EQ:   cond = (opa == opb);
            default: cond = 1'b1;
        endcase
    end

    // offset entry order is 6B, 6B, 4B, 4B, 2B, 2B from the top
    always_ff @(posedge clk) begin
        fields6_s2[0] <= cont6_s1[cont_idx_t'(key_off[17:15])];
        fields6_s2[1] <= cont6_s1[cont_idx_t'(key_off[14:12])];
        fields4_s2[0] <= cont4_s1[cont_idx_t'(key_off[11:9])];
        fields4_s2[1] <= cont4_s1[cont_idx_t'(key_off[8:6])];
        fields2_s2[0] <= cont2_s1[cont_idx_t'(key_off[5:3])];
        fields2_s2[1] <= cont2_s1[cont_idx_t'(key_off[2:0])];
        cond_s2       <= cond;
        phv_s2        <= phv_s1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s2 <= 1'b0;
        end else begin
            valid_s2 <= valid_s1;
        end
    end

endmodule

// ==== design/phv_unpack.sv ====
`timescale 1ns/1ps

module phv_unpack
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  phv_t    phv_in,
    input  logic    phv_valid_in,
    output tenant_t tenant,
    output tenant_t tenant_s1,
    output cont6_t  cont6_s1 [CONT_COUNT],
    output cont4_t  cont4_s1 [CONT_COUNT],
    output cont2_t  cont2_s1 [CONT_COUNT],
    output com_op_t com_op_s1,
    output phv_t    phv_s1,
    output logic    valid_s1
);

    // offset table address, read in the same cycle as the decode
    assign tenant = phv_in[TENANT_LSB +: TENANT_W];

    always_ff @(posedge clk) begin
        for (int i = 0; i < CONT_COUNT; i++) begin
            cont6_s1[i] <= phv_in[CONT6_LSB + i*CONT6_W +: CONT6_W];
            cont4_s1[i] <= phv_in[CONT4_LSB + i*CONT4_W +: CONT4_W];
            cont2_s1[i] <= phv_in[CONT2_LSB + i*CONT2_W +: CONT2_W];
        end
        // stage 0 operation is the highest of the five
        com_op_s1 <= phv_in[OP_LSB + (NUM_STAGES-1-STAGE_ID)*COM_OP_W +: COM_OP_W];
        phv_s1    <= phv_in;
        tenant_s1 <= tenant;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= phv_valid_in;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_s1));

endmodule

// ==== design/cfg_stream_parser.sv ====
`timescale 1ns/1ps

module cfg_stream_parser
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID  = 0,
    parameter int KEY_EX_ID = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  cfg_data_t cfg_in_data,
    input  logic      cfg_in_valid,
    input  logic      cfg_in_last,
    output cfg_data_t cfg_out_data,
    output logic      cfg_out_valid,
    output logic      cfg_out_last,
    output tenant_t   wr_index,
    output logic      off_wr_en,
    output logic      mask_wr_en,
    output key_off_t  off_wr_data,
    output key_t      mask_wr_data
);

    cfg_state_e  state;
    tenant_t     index;
    logic [7:0]  mod_id;
    logic [3:0]  tbl_sel;
    logic [15:0] ctrl_flag;
    logic        claim;
    cfg_data_t   data_swapped;

    assign mod_id    = cfg_in_data[MOD_ID_LSB +: 8];
    assign tbl_sel   = cfg_in_data[TBL_SEL_LSB +: 4];
    assign ctrl_flag = cfg_in_data[CTRL_FLAG_LSB +: 16];

    // header is ours only when stage, extractor id and flag all match
    assign claim = (state == cfg_idle) && cfg_in_valid
                && (mod_id[7:3] == 5'(STAGE_ID))
                && (mod_id[2:0] == 3'(KEY_EX_ID))
                && (ctrl_flag == CFG_CTRL_FLAG);

    // stream is little endian, tables expect big endian
    always_comb begin
        for (int i = 0; i < CFG_W / 8; i++) begin
            data_swapped[CFG_W-1-8*i -: 8] = cfg_in_data[8*i +: 8];
        end
    end

    assign wr_index     = index;
    assign off_wr_en    = cfg_in_valid && (state == cfg_write_off);
    assign mask_wr_en   = cfg_in_valid && (state == cfg_write_mask);
    assign off_wr_data  = data_swapped[CFG_W-1 -: KEY_OFF_W];
    assign mask_wr_data = data_swapped[CFG_W-1 -: KEY_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= cfg_idle;
            index         <= '0;
            cfg_out_valid <= 1'b0;
            cfg_out_last  <= 1'b0;
        end else begin
            case (state)
                cfg_idle: begin
                    if (claim) begin
                        index         <= cfg_in_data[START_IDX_LSB +: TENANT_W];
                        cfg_out_valid <= 1'b0;
                        cfg_out_last  <= 1'b0;
                        // a header-only packet leaves nothing to write
                        if (!cfg_in_last) begin
                            state <= (tbl_sel == '0) ? cfg_write_off : cfg_write_mask;
                        end
                    end else begin
                        cfg_out_valid <= cfg_in_valid;
                        cfg_out_last  <= cfg_in_last;
                    end
                end
                cfg_write_off, cfg_write_mask: begin
                    cfg_out_valid <= 1'b0;
                    cfg_out_last  <= 1'b0;
                    if (cfg_in_valid) begin
                        // 4-bit index wraps past 15 on its own
                        index <= index + 1'b1;
                        if (cfg_in_last) begin
                            state <= cfg_idle;
                        end
                    end
                end
                default: begin
                    state <= cfg_idle;
                end
            endcase
        end
    end

    // forwarded beat data, zeroed while a packet is swallowed
    always_ff @(posedge clk) begin
        cfg_out_data <= (state == cfg_idle && !claim) ? cfg_in_data : '0;
    end

    a_one_table: assert property (@(posedge clk) disable iff (!rst_n)
        !(off_wr_en && mask_wr_en));

    a_quiet_write: assert property (@(posedge clk) disable iff (!rst_n)
        (state != cfg_idle) |-> !cfg_out_valid);

endmodule

// ==== design/tenant_table.sv ====
`timescale 1ns/1ps

module tenant_table
    import key_extract_pkg::*;
#(
    parameter int WIDTH = 18
) (
    input  logic             clk,
    input  logic             wr_en,
    input  tenant_t          wr_index,
    input  logic [WIDTH-1:0] wr_data,
    input  tenant_t          rd_index,
    output logic [WIDTH-1:0] rd_data
);

    logic [WIDTH-1:0] mem [1 << TENANT_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // registered read, a same-cycle write shows up one cycle later
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

// ==== design/key_extract_pkg.sv ====
package key_extract_pkg;

    // container geometry
    localparam int CONT_COUNT = 8;
    localparam int CONT6_W    = 48;
    localparam int CONT4_W    = 32;
    localparam int CONT2_W    = 16;
    localparam int NUM_STAGES = 5;
    localparam int COM_OP_W   = 20;
    localparam int META_W     = 256;
    localparam int PHV_W      = CONT_COUNT * (CONT6_W + CONT4_W + CONT2_W)
                              + NUM_STAGES * COM_OP_W + META_W;

    // containers are packed from the top of the phv, index 7 highest
    localparam int CONT6_LSB = PHV_W - CONT_COUNT * CONT6_W;
    localparam int CONT4_LSB = CONT6_LSB - CONT_COUNT * CONT4_W;
    localparam int CONT2_LSB = CONT4_LSB - CONT_COUNT * CONT2_W;
    // stage 0 operation sits highest, at bits 355:336
    localparam int OP_LSB    = META_W;
    localparam int VLAN_LSB  = 129;
    // tenant is vlan id bits 7:4
    localparam int TENANT_LSB = VLAN_LSB + 4;

    localparam int KEY_OFF_W = 18;
    localparam int KEY_W     = 2 * CONT6_W + 2 * CONT4_W + 2 * CONT2_W + NUM_STAGES;
    localparam int TENANT_W  = 4;
    localparam int CFG_W     = 512;

    // configuration header fields
    localparam int MOD_ID_LSB    = 368;
    localparam int TBL_SEL_LSB   = 380;
    localparam int CTRL_FLAG_LSB = 320;
    localparam int START_IDX_LSB = 384;
    localparam logic [15:0] CFG_CTRL_FLAG = 16'hf2f1;

    // comparator opcodes, code 3 always yields one
    localparam logic [1:0] OP_GT = 2'd0;
    localparam logic [1:0] OP_GE = 2'd1;
    localparam logic [1:0] OP_EQ = 2'd2;

    // operand container types, code 3 gives a zero operand
    localparam logic [1:0] CT_6B = 2'd2;
    localparam logic [1:0] CT_4B = 2'd1;
    localparam logic [1:0] CT_2B = 2'd0;

    typedef logic [PHV_W-1:0]     phv_t;
    typedef logic [CONT6_W-1:0]   cont6_t;
    typedef logic [CONT4_W-1:0]   cont4_t;
    typedef logic [CONT2_W-1:0]   cont2_t;
    typedef logic [2:0]           cont_idx_t;
    typedef logic [COM_OP_W-1:0]  com_op_t;
    typedef logic [7:0]           operand_t;
    typedef logic [KEY_OFF_W-1:0] key_off_t;
    typedef logic [KEY_W-1:0]     key_t;
    typedef logic [TENANT_W-1:0]  tenant_t;
    typedef logic [CFG_W-1:0]     cfg_data_t;

    typedef enum logic [1:0] {
        cfg_idle,
        cfg_write_off,
        cfg_write_mask
    } cfg_state_e;

endpackage
